/* hw/fetch_pkg.sv */
// Fetch front end package with word, address, flag and condition types and opcode values
package fetch_pkg;

	typedef logic [15:0] word_t;	// Instruction or data word
	typedef logic [15:0] addr_t;	// Byte address, bit 0 unused by memory
	typedef logic [2:0]  flags_t;	// {N, V, Z}
	typedef logic [2:0]  cond_t;	// Branch condition field

	// Next-PC source, decoded from the opcode
	typedef enum logic [1:0] {
		BK_B,	// PC relative, conditional
		BK_BR,	// Register target, conditional
		BK_PCS,	// Step to PC+2
		BK_HLT	// Hold PC
	} branch_kind_t;

	localparam int FLAG_Z = 0;	// Zero
	localparam int FLAG_V = 1;	// Overflow
	localparam int FLAG_N = 2;	// Negative

	localparam cond_t COND_NE = 3'd0;	// Z==0
	localparam cond_t COND_EQ = 3'd1;	// Z==1
	localparam cond_t COND_GT = 3'd2;	// Z==N==0
	localparam cond_t COND_LT = 3'd3;	// N==1
	localparam cond_t COND_GE = 3'd4;	// Z==1 or Z==N==0
	localparam cond_t COND_LE = 3'd5;	// N==1 or Z==1
	localparam cond_t COND_OV = 3'd6;	// V==1
	localparam cond_t COND_AL = 3'd7;	// Always

	localparam logic [3:0] OP_B   = 4'hC;
	localparam logic [3:0] OP_BR  = 4'hD;
	localparam logic [3:0] OP_PCS = 4'hE;
	localparam logic [3:0] OP_HLT = 4'hF;

	localparam int OPC_HI  = 15;	// Opcode field
	localparam int OPC_LO  = 12;
	localparam int COND_HI = 11;	// Condition field
	localparam int COND_LO = 9;
	localparam int OFF_HI  = 8;	// B offset field
	localparam int OFF_LO  = 0;

endpackage

/* hw/pc_control.sv */
// Branch condition evaluation against Z, V, N flags and next-PC selection
module pc_control (
	input  fetch_pkg::cond_t        cond,
	input  fetch_pkg::flags_t       flags,
	input  logic [8:0]              offset,
	input  fetch_pkg::addr_t        target,
	input  fetch_pkg::branch_kind_t branch_kind,
	input  fetch_pkg::addr_t        pc,
	output fetch_pkg::addr_t        next_pc
);
	import fetch_pkg::*;

	logic  taken;	// Condition holds
	addr_t pc_inc;	// Sequential PC
	addr_t off_shft;	// Sign-extended offset times two
	addr_t pc_b;	// Relative branch target

	always_comb begin
		case (cond)
			COND_NE: taken = ~flags[FLAG_Z];
			COND_EQ: taken = flags[FLAG_Z];
			COND_GT: taken = ~flags[FLAG_Z] & ~flags[FLAG_N];
			COND_LT: taken = flags[FLAG_N];
			COND_GE: taken = flags[FLAG_Z] | (~flags[FLAG_Z] & ~flags[FLAG_N]);
			COND_LE: taken = flags[FLAG_Z] | flags[FLAG_N];
			COND_OV: taken = flags[FLAG_V];
			COND_AL: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign pc_inc   = pc + addr_t'(2);
	// Sign bit replicated into the top 6, low bit zero for word alignment
	assign off_shft = {{6{offset[8]}}, offset, 1'b0};
	assign pc_b     = pc_inc + off_shft;	// Relative to the next instruction

	always_comb begin
		case (branch_kind)
			BK_B:    next_pc = taken ? pc_b : pc_inc;	// Relative
			BK_BR:   next_pc = taken ? target : pc_inc;	// Register
			BK_PCS:  next_pc = pc_inc;	// Also plain instructions
			BK_HLT:  next_pc = pc;	// Stay put
			default: next_pc = pc_inc;
		endcase
	end

endmodule

/* hw/fetch_unit.sv */
// Fetch unit holding the PC, reading instructions and sending them downstream on credits
module fetch_unit #(
	parameter int OUT_CREDITS = 2
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,
	input  fetch_pkg::flags_t flags,
	input  fetch_pkg::addr_t  reg_target,
	input  logic              grant,
	input  fetch_pkg::word_t  rdata,
	input  logic              out_credit,
	output logic              req,
	output fetch_pkg::addr_t  addr,
	output logic              out_valid,
	output fetch_pkg::addr_t  out_pc,
	output fetch_pkg::word_t  out_instr
);
	import fetch_pkg::*;

	localparam int CW = $clog2(OUT_CREDITS + 1);	// Counter holds 0..OUT_CREDITS

	addr_t         pc;	// Address of the instruction being fetched
	addr_t         next_pc;
	logic          running;	// Cleared by reset and HLT
	logic          pending;	// Read granted, data due this cycle
	logic [CW-1:0] credits;	// Free downstream slots
	branch_kind_t  kind;	// Decoded from returning word

	// Opcode decode, anything outside C..F just steps
	always_comb begin
		case (rdata[OPC_HI:OPC_LO])
			OP_B:    kind = BK_B;
			OP_BR:   kind = BK_BR;
			OP_PCS:  kind = BK_PCS;
			OP_HLT:  kind = BK_HLT;
			default: kind = BK_PCS;
		endcase
	end

	pc_control u_pc_control (
		.cond        (rdata[COND_HI:COND_LO]),
		.flags       (flags),
		.offset      (rdata[OFF_HI:OFF_LO]),
		.target      (reg_target),
		.branch_kind (kind),
		.pc          (pc),
		.next_pc     (next_pc)
	);

	// One read in flight, only with a slot downstream
	assign req       = running & ~pending & (credits != '0);
	assign addr      = pc;
	assign out_valid = pending;	// Data lands the cycle after grant
	assign out_pc    = pc;
	assign out_instr = rdata;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc      <= '0;
			running <= 1'b0;	// Halted out of reset
		end else if (start) begin
			pc      <= '0;
			running <= 1'b1;
		end else if (out_valid) begin
			pc <= next_pc;	// HLT keeps pc
			if (kind == BK_HLT)
				running <= 1'b0;	// HLT already sent this cycle
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pending <= 1'b0;
		else
			pending <= req & grant;	// Self-clears since req drops
	end

	// Send and return in one cycle cancel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			credits <= CW'(OUT_CREDITS);
		else if (out_valid && !out_credit)
			credits <= credits - 1'b1;
		else if (!out_valid && out_credit)
			credits <= credits + 1'b1;
	end

endmodule

/* hw/program_loader.sv */
// Program loader buffering incoming address/data words and writing them to memory
module program_loader #(
	parameter int LOAD_CREDITS = 4
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             ld_valid,
	input  fetch_pkg::addr_t ld_addr,
	input  fetch_pkg::word_t ld_data,
	input  logic             grant,
	output logic             ld_credit,
	output logic             req,
	output fetch_pkg::addr_t addr,
	output fetch_pkg::word_t wdata
);
	import fetch_pkg::*;

	localparam int PW = (LOAD_CREDITS > 1) ? $clog2(LOAD_CREDITS) : 1;	// Pointer width
	localparam int CW = $clog2(LOAD_CREDITS + 1);	// Occupancy width

	addr_t         buf_addr [LOAD_CREDITS];	// Receive buffer, address half
	word_t         buf_data [LOAD_CREDITS];	// Receive buffer, data half
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          pop;

	assign req       = (count != '0);	// Head is waiting
	assign pop       = req & grant;
	assign ld_credit = pop;	// Credit back as the write retires
	assign addr      = buf_addr[rd_ptr];
	assign wdata     = buf_data[rd_ptr];

	// Sender credits guarantee room
	always_ff @(posedge clk) begin
		if (ld_valid) begin
			buf_addr[wr_ptr] <= ld_addr;
			buf_data[wr_ptr] <= ld_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (ld_valid)
				wr_ptr <= (wr_ptr == PW'(LOAD_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;	// Wrap
			if (pop)
				rd_ptr <= (rd_ptr == PW'(LOAD_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			if (ld_valid && !pop)
				count <= count + 1'b1;
			else if (!ld_valid && pop)
				count <= count - 1'b1;
		end
	end

endmodule

/* hw/mem_arbiter.sv */
// Fixed-priority arbiter for the single instruction memory port, loader first
module mem_arbiter (
	input  logic             ld_req,
	input  fetch_pkg::addr_t ld_addr,
	input  fetch_pkg::word_t ld_wdata,
	input  logic             fe_req,
	input  fetch_pkg::addr_t fe_addr,
	output logic             ld_grant,
	output logic             fe_grant,
	output logic             mem_en,
	output logic             mem_we,
	output fetch_pkg::addr_t mem_addr,
	output fetch_pkg::word_t mem_wdata
);
	// Loader always wins, its traffic is bounded by credits
	assign ld_grant = ld_req;
	assign fe_grant = fe_req & ~ld_req;	// Fetch waits out loader writes

	assign mem_en    = ld_req | fe_req;	// Port busy when anyone asks
	assign mem_we    = ld_grant;	// Loader only writes, fetch only reads
	assign mem_addr  = ld_grant ? ld_addr : fe_addr;
	assign mem_wdata = ld_wdata;	// Ignored on reads

endmodule

/* hw/imem.sv */
// Single-port instruction memory with synchronous write and one-cycle registered read
module imem #(
	parameter int MEM_WORDS = 256
) (
	input  logic             clk,
	input  logic             en,
	input  logic             we,
	input  fetch_pkg::addr_t addr,
	input  fetch_pkg::word_t wdata,
	output fetch_pkg::word_t rdata
);
	import fetch_pkg::*;

	localparam int AW = $clog2(MEM_WORDS);	// Word index width

	word_t         mem [MEM_WORDS];
	logic [AW-1:0] idx;

	assign idx = addr[AW:1];	// Byte address to word index

	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[idx] <= wdata;	// Visible from the next cycle
			else
				rdata <= mem[idx];	// Data one cycle after grant
		end
	end

endmodule

/* hw/fetch_top.sv */
// Fetch front end top level joining loader, fetch unit, arbiter and instruction memory
module fetch_top #(
	parameter int MEM_WORDS    = 256,
	parameter int LOAD_CREDITS = 4,
	parameter int OUT_CREDITS  = 2
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              ld_valid,
	input  fetch_pkg::addr_t  ld_addr,
	input  fetch_pkg::word_t  ld_data,
	input  logic              start,
	input  fetch_pkg::flags_t flags,
	input  fetch_pkg::addr_t  reg_target,
	input  logic              out_credit,
	output logic              ld_credit,
	output logic              out_valid,
	output fetch_pkg::addr_t  out_pc,
	output fetch_pkg::word_t  out_instr
);
	import fetch_pkg::*;

	logic  ld_req;	// Loader side of arbiter
	logic  ld_grant;
	addr_t ld_mem_addr;
	word_t ld_wdata;
	logic  fe_req;	// Fetch side of arbiter
	logic  fe_grant;
	addr_t fe_addr;
	logic  mem_en;	// Memory port
	logic  mem_we;
	addr_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;

	program_loader #(.LOAD_CREDITS(LOAD_CREDITS)) u_loader (
		.clk(clk), .arst_n(arst_n),
		.ld_valid(ld_valid), .ld_addr(ld_addr), .ld_data(ld_data),
		.grant(ld_grant), .ld_credit(ld_credit),
		.req(ld_req), .addr(ld_mem_addr), .wdata(ld_wdata)
	);

	fetch_unit #(.OUT_CREDITS(OUT_CREDITS)) u_fetch (
		.clk(clk), .arst_n(arst_n), .start(start),
		.flags(flags), .reg_target(reg_target),
		.grant(fe_grant), .rdata(mem_rdata), .out_credit(out_credit),
		.req(fe_req), .addr(fe_addr),
		.out_valid(out_valid), .out_pc(out_pc), .out_instr(out_instr)
	);

	mem_arbiter u_arb (
		.ld_req(ld_req), .ld_addr(ld_mem_addr), .ld_wdata(ld_wdata),
		.fe_req(fe_req), .fe_addr(fe_addr),
		.ld_grant(ld_grant), .fe_grant(fe_grant),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	imem #(.MEM_WORDS(MEM_WORDS)) u_imem (
		.clk(clk), .en(mem_en), .we(mem_we),
		.addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
	);

endmodule

/* verification/fetch_tb.sv */
// Testbench for the fetch front end, replaying load, start and expect records from a file
module fetch_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import fetch_pkg::*;

	localparam int LOAD_CREDITS = 4;
	localparam int OUT_CREDITS  = 2;
	localparam int WAIT_LIMIT   = 400;	// Cycles per bounded wait
	localparam int HALT_WINDOW  = 40;	// Quiet cycles expected after HLT

	logic   clk = 1'b0;
	logic   arst_n;
	logic   ld_valid;
	addr_t  ld_addr;
	word_t  ld_data;
	logic   start;
	flags_t flags;
	addr_t  reg_target;
	logic   out_credit = 1'b0;	// Driven by the receiver model only
	logic   ld_credit;
	logic   out_valid;
	addr_t  out_pc;
	word_t  out_instr;

	addr_t  seen_pc [1024];	// Captured fetch outputs
	word_t  seen_instr [1024];
	int     out_recv = 0;	// Written by output monitor
	int     out_returned = 0;	// Written by receiver model
	int     ld_returned = 0;	// Written by credit monitor
	int     mon_errs = 0;
	int     ld_sent;
	int     rd_idx;
	int     errors;
	int     tests;
	int     failed_tests;
	int     test_mark;
	int     gap = 0;	// Receiver delay before next return
	integer seed = 32'hfeec_e67b;

	fetch_top #(.LOAD_CREDITS(LOAD_CREDITS), .OUT_CREDITS(OUT_CREDITS)) DUT (
		.clk(clk), .arst_n(arst_n),
		.ld_valid(ld_valid), .ld_addr(ld_addr), .ld_data(ld_data),
		.start(start), .flags(flags), .reg_target(reg_target),
		.out_credit(out_credit), .ld_credit(ld_credit),
		.out_valid(out_valid), .out_pc(out_pc), .out_instr(out_instr)
	);

	always #4 clk = ~clk;	// 8 ns period

	// Output monitor, mid-cycle sample
	always @(negedge clk) begin
		if (arst_n === 1'b1 && out_valid === 1'b1) begin
			if (out_recv - out_returned >= OUT_CREDITS) begin
				$display("Fetch sent an instruction with no downstream credit at %0t", $time);
				mon_errs++;
			end
			seen_pc[out_recv[9:0]]    = out_pc;
			seen_instr[out_recv[9:0]] = out_instr;
			out_recv++;
		end
		if (arst_n === 1'b1 && ld_credit === 1'b1) begin
			ld_returned++;
			if (ld_returned > ld_sent) begin
				$display("Loader returned a credit for a word never sent at %0t", $time);
				mon_errs++;
			end
		end
	end

	// Receiver model, random return delay
	always @(posedge clk) begin
		#1;
		out_credit = 1'b0;
		if (out_recv > out_returned) begin
			if (gap == 0) begin
				out_credit = 1'b1;
				out_returned++;
				gap = $random(seed) & 7;
			end else
				gap--;
		end
	end

	task automatic step();
		@(posedge clk);
		#1;	// Inputs change just after the edge
	endtask

	task automatic check_addr(input string sig, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got %h exp %h", $time, sig, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input string sig, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got %h exp %h", $time, sig, got, exp);
			errors++;
		end
	endtask

	task automatic check_credits(input string sig, input int got, input int exp);
		if (got != exp) begin
			$display("ERR t=%0t %s got %0d exp %0d", $time, sig, got, exp);
			errors++;
		end
	endtask

	task automatic send_word(input addr_t a, input word_t d);
		int n;
		n = 0;
		while (ld_sent - ld_returned >= LOAD_CREDITS && n < WAIT_LIMIT) begin	// No credit
			step();
			n++;
		end
		if (n == WAIT_LIMIT) begin
			$display("Timed out waiting for a loader credit at %0t", $time);
			errors++;
		end else begin
			ld_valid = 1'b1;
			ld_addr  = a;
			ld_data  = d;
			ld_sent++;
			step();
			ld_valid = 1'b0;
		end
	endtask

	task automatic wait_loads_done();
		int n;
		n = 0;
		while (ld_returned != ld_sent && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (n == WAIT_LIMIT) begin
			$display("Timed out waiting for loaded words to retire at %0t", $time);
			errors++;
		end
	endtask

	task automatic start_run(input flags_t f, input addr_t t);
		wait_loads_done();	// Program must be in memory
		flags      = f;
		reg_target = t;
		start      = 1'b1;
		step();
		start      = 1'b0;
	endtask

	task automatic expect_out(input addr_t p, input word_t w);
		int n;
		n = 0;
		while (rd_idx >= out_recv && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (n == WAIT_LIMIT) begin
			$display("Timed out waiting for fetch of pc %h at %0t", p, $time);
			errors++;
		end else begin
			check_addr("out_pc", seen_pc[rd_idx[9:0]], p);
			check_word("out_instr", seen_instr[rd_idx[9:0]], w);
			rd_idx++;
		end
	endtask

	task automatic end_test(input logic [8*24-1:0] name);
		int bad;
		wait_loads_done();
		repeat (HALT_WINDOW) step();	// Halted unit stays quiet
		check_credits("out_valid count", out_recv, rd_idx);	// Nothing past HLT
		rd_idx = out_recv;
		bad = errors + mon_errs - test_mark;
		$display("test %0s: %0s, %0d errors", name, (bad == 0) ? "passed" : "failed", bad);
		tests++;
		if (bad != 0)
			failed_tests++;
		test_mark = errors + mon_errs;
	endtask

	initial begin
		int               fd;
		int               r;
		byte              kind;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [8*24-1:0]  name;
		string            skip;
		arst_n = 1'b0;
		ld_valid = 1'b0;
		ld_addr = '0;
		ld_data = '0;
		start = 1'b0;
		flags = '0;
		reg_target = '0;
		ld_sent = 0;
		rd_idx = 0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		test_mark = 0;
		repeat (3) @(posedge clk);
		#1 arst_n = 1'b1;
		step();
		fd = $fopen("verification/fetch_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			errors++;
		end else begin
			while ($fscanf(fd, " %c", kind) == 1) begin
				case (kind)
					"#": r = $fgets(skip, fd);
					"L": begin
						r = $fscanf(fd, "%h %h", a, b);
						send_word(a[15:0], b[15:0]);
					end
					"S": begin
						r = $fscanf(fd, "%h %h", a, b);
						start_run(a[2:0], b[15:0]);
					end
					"E": begin
						r = $fscanf(fd, "%h %h", a, b);
						expect_out(a[15:0], b[15:0]);
					end
					"T": begin
						r = $fscanf(fd, "%s", name);
						end_test(name);
					end
					default: begin
						$display("Unknown record kind in stimulus file");
						errors++;
					end
				endcase
			end
			$fclose(fd);
		end
		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors + mon_errs);
		if (errors + mon_errs == 0 && tests > 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* verification/fetch_input.txt */
# L addr data | S flags(N,V,Z) reg_target | E pc instr | T name, all hex
# Program: B cond +1 with filler after each, BR always to 30, B always -3 to 2c, HLT
L 0 1100
L 2 1102
L 4 1104
L 6 F000
S 0 0
E 0 1100
E 2 1102
E 4 1104
E 6 F000
T load_seq
L 0 C001
L 2 E000
L 4 C201
L 6 1006
L 8 C401
L a 100A
L c C601
L e 100E
L 10 C801
L 12 1012
L 14 CA01
L 16 1016
L 18 CC01
L 1a 101A
L 1c DE00
L 30 CFFD
L 2c F000
S 1 30
E 0 C001
E 2 E000
E 4 C201
E 8 C401
E a 100A
E c C601
E e 100E
E 10 C801
E 14 CA01
E 18 CC01
E 1a 101A
E 1c DE00
E 30 CFFD
E 2c F000
T branch_z
S 4 30
E 0 C001
E 4 C201
E 6 1006
E 8 C401
E a 100A
E c C601
E 10 C801
E 12 1012
E 14 CA01
E 18 CC01
E 1a 101A
E 1c DE00
E 30 CFFD
E 2c F000
T branch_n
S 2 30
L 80 5A80
L 82 5A82
L 84 5A84
L 86 5A86
L 88 5A88
E 0 C001
E 4 C201
E 6 1006
E 8 C401
E c C601
E e 100E
E 10 C801
E 14 CA01
E 16 1016
E 18 CC01
E 1c DE00
E 30 CFFD
E 2c F000
T branch_v_load

/* fetch_top.f */
hw/fetch_pkg.sv
hw/pc_control.sv
hw/fetch_unit.sv
hw/program_loader.sv
hw/mem_arbiter.sv
hw/imem.sv
hw/fetch_top.sv
verification/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	-f fetch_top.f --top-module fetch_tb -o fetch_sim
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "Everything OK" sim.log; then
	exit 0
fi
exit 1
